/* sources.f */
hw/permutePkg.sv
hw/botInputFifo.sv
hw/permuteScheduler.sv
hw/permuteNetwork.sv
hw/permuteResult.sv
hw/botPermuterTop.sv
sim/botPermuterProperties.sv
sim/botPermuterTb.sv

/* run.sh */
#!/bin/sh
# Builds and runs the bot permuter testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module botPermuterTb \
        -f sources.f -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

if ! simOutput=$(./obj_dir/VbotPermuterTb); then
    echo "$simOutput"
    echo "Simulation exited with an error status"
    exit 1
fi
echo "$simOutput"

if echo "$simOutput" | grep -qx "Test completed successfully"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* sim/botPermuterTb.sv */
`timescale 1ns/100ps
`default_nettype none

module botPermuterTb;
    import permutePkg::*;

    localparam int ROWS           = 12;
    localparam int RUNS           = 3;
    localparam int TIMEOUT_CYCLES = RUNS * ROWS * 8 + 200;

    logic       clk;
    logic       rst;
    botT        bot;
    permMaskT   permMask;
    logic       batchDone;
    logic       writeData;
    logic       slowDownInput;
    logic       requestSlowDown;
    botT        permutedBot;
    logic       permutedBotValid;
    logic       batchFinished;
    batchCountT batchCount;

    // Stimulus table with the expected batch count on batch-end rows
    botT        rowBot   [ROWS];
    permMaskT   rowMask  [ROWS];
    logic       rowDone  [ROWS];
    batchCountT rowCount [ROWS];

    // Source variables landing at A, B, C for each permutation index
    string      permNames [6] = '{"ABC", "ACB", "BAC", "BCA", "CAB", "CBA"};

    botT        expBotQ   [$];
    logic       expLastQ  [$];
    batchCountT expCountQ [$];
    logic       expAloneQ [$];

    string      testName;
    int         valueErrors;
    int         protocolErrors;
    int         cycleCount = 0;
    logic       expLast;
    logic       expAlone;

    botPermuterTop #(
        .FIFO_DEPTH_LOG2(4),
        .SLOW_THRESHOLD (10)
    ) i_dut (.*);

    always #20 clk = ~clk;

    function automatic botT randomBot();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // Output bit j reads input bit k that keeps j's upper bits
    function automatic botT permuteRef(input botT src, input permIndexT index);
        botT        dst;
        string      name;
        logic [6:0] outIdx;
        logic [6:0] srcIdx;
        logic [7:0] letter;
        name = permNames[index];
        for (int j = 0; j < BOT_WIDTH; j++) begin
            outIdx = 7'(j);
            srcIdx = outIdx;
            // Output variable v goes to the source position its letter names
            for (int v = 0; v < 3; v++) begin
                letter = name[v];
                srcIdx[2'(letter - "A")] = outIdx[v];
            end
            dst[j] = src[srcIdx];
        end
        return dst;
    endfunction

    task automatic setRow(input int r, input botT b, input permMaskT m, input logic d,
                          input batchCountT c);
        rowBot[r]   = b;
        rowMask[r]  = m;
        rowDone[r]  = d;
        rowCount[r] = c;
    endtask

    task automatic fillTable();
        setRow(0,  randomBot(),  6'b100000, 1'b0, 8'd0);
        // Projection of variable B
        setRow(1,  {32{4'hC}},   6'b010000, 1'b0, 8'd0);
        // Projection of variable A
        setRow(2,  {32{4'hA}},   6'b001000, 1'b0, 8'd0);
        setRow(3,  randomBot(),  6'b000100, 1'b0, 8'd0);
        // Projection of variable C
        setRow(4,  {16{8'hF0}},  6'b000010, 1'b0, 8'd0);
        setRow(5,  randomBot(),  6'b000001, 1'b1, 8'd6);
        // Marker-only batch
        setRow(6,  randomBot(),  6'b000000, 1'b1, 8'd0);
        setRow(7,  randomBot(),  6'b111111, 1'b0, 8'd0);
        // Dropped without output
        setRow(8,  '1,           6'b000000, 1'b0, 8'd0);
        setRow(9,  {8{16'h6996}}, 6'b101010, 1'b1, 8'd9);
        setRow(10, randomBot(),  6'b010101, 1'b0, 8'd0);
        setRow(11, 128'h0123_4567_89AB_CDEF_FEDC_BA98_7654_3210, 6'b110011, 1'b1, 8'd7);
    endtask

    // Mask bits go from bit 5 down to bit 0
    task automatic buildExpected();
        permMaskT lowerMask;
        for (int r = 0; r < ROWS; r++) begin
            for (int b = MASK_WIDTH - 1; b >= 0; b--) begin
                lowerMask = permMaskT'((1 << b) - 1);
                if (rowMask[r][b]) begin
                    // ABC leaves the table as it is
                    if (b == MASK_WIDTH - 1) begin
                        expBotQ.push_back(rowBot[r]);
                    end else begin
                        expBotQ.push_back(permuteRef(rowBot[r], permIndexT'(MASK_WIDTH - 1 - b)));
                    end
                    expLastQ.push_back(rowDone[r] && ((rowMask[r] & lowerMask) == '0));
                end
            end
            if (rowDone[r]) begin
                expCountQ.push_back(rowCount[r]);
                expAloneQ.push_back(rowMask[r] == '0);
            end
        end
    endtask

    task automatic checkBot(input string name, input botT expected, input botT actual);
        if (expected !== actual) begin
            valueErrors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkCount(input string name, input batchCountT expected,
                              input batchCountT actual);
        if (expected !== actual) begin
            valueErrors++;
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            valueErrors++;
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic pushRows(input logic honorSlowDown);
        for (int r = 0; r < ROWS; r++) begin
            // Producer holds off while the FIFO asks for it
            while (honorSlowDown && slowDownInput) begin
                writeData = 1'b0;
                @(negedge clk);
            end
            bot       = rowBot[r];
            permMask  = rowMask[r];
            batchDone = rowDone[r];
            writeData = 1'b1;
            @(negedge clk);
        end
        writeData = 1'b0;
    endtask

    task automatic randomStall();
        while (expBotQ.size() != 0 || expCountQ.size() != 0) begin
            requestSlowDown = 1'($urandom() % 2);
            @(negedge clk);
        end
        requestSlowDown = 1'b0;
    endtask

    task automatic waitDrained();
        while (expBotQ.size() != 0 || expCountQ.size() != 0) begin
            @(negedge clk);
        end
        // Idle cycles so stray outputs still show up
        repeat (4) @(negedge clk);
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (permutedBotValid) begin
                if (expBotQ.size() == 0) begin
                    protocolErrors++;
                    $display("Unexpected output bot %h in %s", permutedBot, testName);
                end else begin
                    expLast = expLastQ.pop_front();
                    checkBot(testName, expBotQ.pop_front(), permutedBot);
                    if (expLast !== batchFinished) begin
                        protocolErrors++;
                        $display("batchFinished not aligned with last output in %s", testName);
                    end
                end
            end
            if (batchFinished) begin
                if (expCountQ.size() == 0) begin
                    protocolErrors++;
                    $display("Unexpected batchFinished pulse in %s", testName);
                end else begin
                    expAlone = expAloneQ.pop_front();
                    checkCount({testName, " batchCount"}, expCountQ.pop_front(), batchCount);
                    if (expAlone === permutedBotValid) begin
                        protocolErrors++;
                        $display("batchFinished arrived with wrong output valid in %s", testName);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped producing results", cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        bot             = '0;
        permMask        = '0;
        batchDone       = 1'b0;
        writeData       = 1'b0;
        requestSlowDown = 1'b0;
        valueErrors     = 0;
        protocolErrors  = 0;
        testName        = "reset";
        void'($urandom(77));
        fillTable();
        repeat (5) @(negedge clk);
        rst = 1'b0;
        checkFlag("reset slowDownInput", 1'b0, slowDownInput);
        checkFlag("reset permutedBotValid", 1'b0, permutedBotValid);
        checkFlag("reset batchFinished", 1'b0, batchFinished);
        checkCount("reset batchCount", '0, batchCount);

        testName = "unstalled run";
        buildExpected();
        pushRows(1'b1);
        waitDrained();

        testName = "random stall run";
        buildExpected();
        fork
            pushRows(1'b1);
            randomStall();
        join
        waitDrained();

        // Consumer stall lets the FIFO fill past the threshold
        testName = "fill level run";
        buildExpected();
        requestSlowDown = 1'b1;
        pushRows(1'b0);
        @(negedge clk);
        checkFlag("slowDownInput raised", 1'b1, slowDownInput);
        requestSlowDown = 1'b0;
        waitDrained();
        checkFlag("slowDownInput released", 1'b0, slowDownInput);

        $display("Errors: %0d value mismatches, %0d protocol errors", valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/botPermuterProperties.sv */
`timescale 1ns/100ps
`default_nettype none

module botPermuterProperties (
    input logic clk,
    input logic rst,
    input logic requestSlowDown,
    input logic issueValid,
    input logic issueLast,
    input logic pop,
    input logic empty,
    input logic slowDownInput,
    input logic permutedBotValid,
    input logic batchFinished
);

    // Consumer stall stops the scheduler in the same cycle
    stallHoldsIssue: assert property (@(posedge clk) disable iff (rst)
        requestSlowDown |-> !issueValid && !issueLast && !pop)
        else $error("Scheduler issued or popped while requestSlowDown was high");

    popNeedsData: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty)
        else $error("Scheduler popped an empty FIFO");

    // Registered outputs settle after the first reset edge
    resetQuietsOutputs: assert property (@(posedge clk)
        rst && $past(rst) |-> !slowDownInput && !permutedBotValid && !batchFinished)
        else $error("Outputs active during reset");

endmodule

bind botPermuterTop botPermuterProperties i_properties (
    .clk             (clk),
    .rst             (rst),
    .requestSlowDown (requestSlowDown),
    .issueValid      (issueValid),
    .issueLast       (issueLast),
    .pop             (pop),
    .empty           (fifoEmpty),
    .slowDownInput   (slowDownInput),
    .permutedBotValid(permutedBotValid),
    .batchFinished   (batchFinished)
);

`default_nettype wire

/* hw/botPermuterTop.sv */
`timescale 1ns/100ps
`default_nettype none

module botPermuterTop #(
    parameter int FIFO_DEPTH_LOG2 = 4,
    parameter int SLOW_THRESHOLD  = 10
) (
    input  logic                   clk,
    input  logic                   rst,
    // Producer side
    input  permutePkg::botT        bot,
    input  permutePkg::permMaskT   permMask,
    input  logic                   batchDone,
    input  logic                   writeData,
    output logic                   slowDownInput,
    // Consumer side
    input  logic                   requestSlowDown,
    output permutePkg::botT        permutedBot,
    output logic                   permutedBotValid,
    output logic                   batchFinished,
    output permutePkg::batchCountT batchCount
);
    import permutePkg::*;

    botT       headBot;
    permMaskT  headMask;
    logic      headBatchDone;
    logic      fifoEmpty;
    logic      pop;

    logic      issueValid;
    logic      issueLast;
    permIndexT permIndex;
    botT       issueBot;

    logic      outValid;
    logic      outLast;
    botT       outBot;

    botInputFifo #(
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2),
        .SLOW_THRESHOLD (SLOW_THRESHOLD)
    ) i_inputFifo (
        .clk          (clk),
        .rst          (rst),
        .writeData    (writeData),
        .botIn        (bot),
        .maskIn       (permMask),
        .batchDoneIn  (batchDone),
        .pop          (pop),
        .headBot      (headBot),
        .headMask     (headMask),
        .headBatchDone(headBatchDone),
        .empty        (fifoEmpty),
        .slowDownInput(slowDownInput)
    );

    permuteScheduler i_scheduler (
        .clk            (clk),
        .rst            (rst),
        .empty          (fifoEmpty),
        .headBot        (headBot),
        .headMask       (headMask),
        .headBatchDone  (headBatchDone),
        .requestSlowDown(requestSlowDown),
        .pop            (pop),
        .issueValid     (issueValid),
        .issueLast      (issueLast),
        .permIndex      (permIndex),
        .issueBot       (issueBot)
    );

    // Two cycles from issue to result
    permuteNetwork i_network (
        .clk       (clk),
        .rst       (rst),
        .issueValid(issueValid),
        .issueLast (issueLast),
        .permIndex (permIndex),
        .issueBot  (issueBot),
        .outValid  (outValid),
        .outLast   (outLast),
        .outBot    (outBot)
    );

    permuteResult i_result (
        .clk             (clk),
        .rst             (rst),
        .outValid        (outValid),
        .outLast         (outLast),
        .outBot          (outBot),
        .permutedBot     (permutedBot),
        .permutedBotValid(permutedBotValid),
        .batchFinished   (batchFinished),
        .batchCount      (batchCount)
    );

endmodule

`default_nettype wire

/* hw/permuteResult.sv */
`timescale 1ns/100ps
`default_nettype none

module permuteResult (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   outValid,
    input  logic                   outLast,
    input  permutePkg::botT        outBot,
    output permutePkg::botT        permutedBot,
    output logic                   permutedBotValid,
    output logic                   batchFinished,
    output permutePkg::batchCountT batchCount
);
    import permutePkg::*;

    batchCountT runningCount;
    batchCountT countWithCurrent;

    // Data path adds no latency
    assign permutedBot      = outBot;
    assign permutedBotValid = outValid;

    // Last marker lines up with the final output of the batch
    assign batchFinished    = outLast;

    // Includes the output of this cycle, wraps at 256
    assign countWithCurrent = runningCount + batchCountT'(outValid);
    assign batchCount       = countWithCurrent;

    always_ff @(posedge clk) begin
        if (rst) begin
            runningCount <= '0;
        end else if (outLast) begin
            runningCount <= '0;
        end else begin
            runningCount <= countWithCurrent;
        end
    end

endmodule

`default_nettype wire

/* hw/permuteNetwork.sv */
`timescale 1ns/100ps
`default_nettype none

module permuteNetwork (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issueValid,
    input  logic                  issueLast,
    input  permutePkg::permIndexT permIndex,
    input  permutePkg::botT       issueBot,
    output logic                  outValid,
    output logic                  outLast,
    output permutePkg::botT       outBot
);
    import permutePkg::*;

    localparam int HALF_WIDTH = BOT_WIDTH / 2;

    logic [HALF_WIDTH-1:0] lowShuffledQ;
    logic [HALF_WIDTH-1:0] highRawQ;
    permIndexT             indexQ;
    logic                  validQ;
    logic                  lastQ;

    // Each output bit picks one of eight sources in its aligned group of eight
    function automatic logic [HALF_WIDTH-1:0] shuffleHalf(input logic [HALF_WIDTH-1:0] src,
                                                          input permIndexT index);
        logic [HALF_WIDTH-1:0] dst;
        logic [2:0]            lowSrc;
        logic [5:0]            outIdx;
        dst = '0;
        for (int j = 0; j < HALF_WIDTH; j++) begin
            outIdx = 6'(j);
            lowSrc = permSourceLow(outIdx[2:0], index);
            dst[j] = src[{outIdx[5:3], lowSrc}];
        end
        return dst;
    endfunction

    // Stage one shuffles the low half, the high half waits a cycle
    always_ff @(posedge clk) begin
        lowShuffledQ <= shuffleHalf(issueBot[HALF_WIDTH-1:0], permIndex);
        highRawQ     <= issueBot[BOT_WIDTH-1:HALF_WIDTH];
        indexQ       <= permIndex;
    end

    // Stage two shuffles the high half with the delayed index
    always_ff @(posedge clk) begin
        outBot <= {shuffleHalf(highRawQ, indexQ), lowShuffledQ};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validQ   <= 1'b0;
            lastQ    <= 1'b0;
            outValid <= 1'b0;
            outLast  <= 1'b0;
        end else begin
            validQ   <= issueValid;
            lastQ    <= issueLast;
            outValid <= validQ;
            outLast  <= lastQ;
        end
    end

endmodule

`default_nettype wire

/* hw/permuteScheduler.sv */
`timescale 1ns/100ps
`default_nettype none

module permuteScheduler (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  empty,
    input  permutePkg::botT       headBot,
    input  permutePkg::permMaskT  headMask,
    input  logic                  headBatchDone,
    input  logic                  requestSlowDown,
    output logic                  pop,
    output logic                  issueValid,
    output logic                  issueLast,
    output permutePkg::permIndexT permIndex,
    output permutePkg::botT       issueBot
);
    import permutePkg::*;

    typedef enum logic {
        stateIdle,
        stateExpanding
    } schedStateT;

    schedStateT state;
    botT        curBot;
    permMaskT   remMask;
    logic       curDone;

    permMaskT   srcMask;
    permMaskT   restMask;
    logic       srcDone;
    logic       hasBit;
    logic [2:0] bitPos;
    logic       grab;
    logic       active;
    logic       wordDone;

    // Idle issues straight from the FIFO head, expanding from the held word
    assign srcMask  = (state == stateIdle) ? headMask : remMask;
    assign srcDone  = (state == stateIdle) ? headBatchDone : curDone;
    assign issueBot = (state == stateIdle) ? headBot : curBot;

    assign grab   = (state == stateIdle) && !empty && !requestSlowDown;
    assign active = grab || ((state == stateExpanding) && !requestSlowDown);

    // Highest set mask bit goes first
    always_comb begin
        hasBit = 1'b0;
        bitPos = '0;
        for (int i = 0; i < MASK_WIDTH; i++) begin
            if (srcMask[i]) begin
                hasBit = 1'b1;
                bitPos = 3'(i);
            end
        end
        restMask = srcMask;
        if (hasBit) begin
            restMask[bitPos] = 1'b0;
        end
    end

    assign wordDone   = (restMask == '0);
    assign permIndex  = permIndexT'(MASK_WIDTH - 1) - bitPos;
    assign issueValid = active && hasBit;
    // Also fires alone for an empty-mask batch-end word
    assign issueLast  = active && wordDone && srcDone;

    // Next word is taken on the cycle the current one runs out
    assign pop = grab || ((state == stateExpanding) && !requestSlowDown && wordDone && !empty);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stateIdle;
        end else if (active) begin
            if (!wordDone) begin
                state <= stateExpanding;
            end else if (state == stateExpanding && !empty) begin
                state <= stateExpanding;
            end else begin
                state <= stateIdle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            remMask <= '0;
            curDone <= 1'b0;
        end else if (active) begin
            if (!wordDone) begin
                remMask <= restMask;
                curDone <= srcDone;
            end else if (state == stateExpanding && !empty) begin
                remMask <= headMask;
                curDone <= headBatchDone;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            curBot <= headBot;
        end
    end

endmodule

`default_nettype wire

/* hw/botInputFifo.sv */
`timescale 1ns/100ps
`default_nettype none

module botInputFifo #(
    parameter int FIFO_DEPTH_LOG2 = 4,
    parameter int SLOW_THRESHOLD  = 10
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 writeData,
    input  permutePkg::botT      botIn,
    input  permutePkg::permMaskT maskIn,
    input  logic                 batchDoneIn,
    input  logic                 pop,
    output permutePkg::botT      headBot,
    output permutePkg::permMaskT headMask,
    output logic                 headBatchDone,
    output logic                 empty,
    output logic                 slowDownInput
);
    import permutePkg::*;

    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;
    localparam logic [FIFO_DEPTH_LOG2:0] FULL_LEVEL = (FIFO_DEPTH_LOG2 + 1)'(DEPTH);
    localparam logic [FIFO_DEPTH_LOG2:0] SLOW_LEVEL = (FIFO_DEPTH_LOG2 + 1)'(SLOW_THRESHOLD);

    botT      botMem  [DEPTH];
    permMaskT maskMem [DEPTH];
    logic     doneMem [DEPTH];

    logic [FIFO_DEPTH_LOG2-1:0] writePtr;
    logic [FIFO_DEPTH_LOG2-1:0] readPtr;
    logic [FIFO_DEPTH_LOG2:0]   fillCount;
    logic                       full;
    logic                       doPush;
    logic                       doPop;

    assign full   = (fillCount == FULL_LEVEL);
    assign empty  = (fillCount == '0);
    // Pushes into a full FIFO are dropped
    assign doPush = writeData && !full;
    assign doPop  = pop && !empty;

    // First-word-fall-through head
    assign headBot       = botMem[readPtr];
    assign headMask      = maskMem[readPtr];
    assign headBatchDone = doneMem[readPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            botMem[writePtr]  <= botIn;
            maskMem[writePtr] <= maskIn;
            doneMem[writePtr] <= batchDoneIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr      <= '0;
            readPtr       <= '0;
            fillCount     <= '0;
            slowDownInput <= 1'b0;
        end else begin
            if (doPush) begin
                writePtr <= writePtr + 1'b1;
            end
            if (doPop) begin
                readPtr <= readPtr + 1'b1;
            end
            unique case ({doPush, doPop})
                2'b10:   fillCount <= fillCount + 1'b1;
                2'b01:   fillCount <= fillCount - 1'b1;
                default: fillCount <= fillCount;
            endcase
            // Follows the fill level one cycle late
            slowDownInput <= (fillCount > SLOW_LEVEL);
        end
    end

endmodule

`default_nettype wire

/* hw/permutePkg.sv */
`default_nettype none

// Permutation rule for a seven-variable truth table:
// output bit j takes input bit k, where k[6:3] == j[6:3].
// For every output variable position v in {A, B, C} (bits 0, 1, 2 of j),
// j[v] is placed at k[PERM_SRC_POS[index][v]].
// So the permutation name lists the source variable that lands at A, B and C.
package permutePkg;

    localparam int BOT_WIDTH   = 128;
    localparam int MASK_WIDTH  = 6;
    localparam int COUNT_WIDTH = 8;
    localparam int PERM_COUNT  = 6;

    typedef logic [BOT_WIDTH-1:0]   botT;
    typedef logic [MASK_WIDTH-1:0]  permMaskT;
    typedef logic [2:0]             permIndexT;
    typedef logic [COUNT_WIDTH-1:0] batchCountT;

    // Source bit position of output variables A, B, C per permutation index
    // Index 0 is mask bit 5 (ABC), index 5 is mask bit 0 (CBA)
    localparam logic [1:0] PERM_SRC_POS [0:PERM_COUNT-1][0:2] = '{
        '{2'd0, 2'd1, 2'd2},  // ABC
        '{2'd0, 2'd2, 2'd1},  // ACB
        '{2'd1, 2'd0, 2'd2},  // BAC
        '{2'd1, 2'd2, 2'd0},  // BCA
        '{2'd2, 2'd0, 2'd1},  // CAB
        '{2'd2, 2'd1, 2'd0}   // CBA
    };

    // Low three bits of the source index for a given output index
    function automatic logic [2:0] permSourceLow(input logic [2:0] outLow,
                                                 input permIndexT index);
        logic [2:0] srcLow;
        srcLow = '0;
        for (int v = 0; v < 3; v++) begin
            srcLow[PERM_SRC_POS[index][v]] = outLow[v];
        end
        return srcLow;
    endfunction

endpackage

`default_nettype wire
